// File: Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
LINT      := --lint-only --timing -Wall
TOP       := lsu_tb
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
RUN_FLAGS := +verilator+error+limit+1000
PASS_MSG  := Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: rtl/data_ram.sv
//==============================
// Byte-writable word RAM, one access at a time.
// Upper address bits above bit 9 are ignored, so the RAM aliases.
//==============================
module data_ram (
    input  logic              clk,
    input  logic              rst_n,
    input  lsu_pkg::bus_req_t bus_i,
    input  logic              hold_i,
    output logic              gnt_o,
    output logic              rvalid_o,
    output logic [31:0]       rdata_o
);
    import lsu_pkg::*;

    logic [31:0]       mem_q [RAM_WORDS];
    logic [RAM_AW-1:0] word_idx;
    logic [31:0]       rdata_q;
    logic              rvalid_q;

    assign word_idx = bus_i.addr[RAM_AW+1:2];
    assign gnt_o    = bus_i.req & ~hold_i;  // An arbiter that is busy holds the grant.

    // Writes and the read both happen on the grant edge.
    always_ff @(posedge clk) begin
        if (gnt_o) begin
            for (int b = 0; b < 4; b++) begin
                if (bus_i.we && bus_i.be[b]) begin
                    mem_q[word_idx][b*8 +: 8] <= bus_i.wdata[b*8 +: 8];
                end
            end
            rdata_q <= mem_q[word_idx];    // Old contents on a store.
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= gnt_o;              // One pulse per grant.
        end
    end

    assign rvalid_o = rvalid_q;
    assign rdata_o  = rdata_q;

endmodule

// File: rtl/lsu_align.sv
//==============================
// Byte-lane logic, fully combinational.
// The load result is valid only while rdata_i holds the RAM reply.
//==============================
module lsu_align (
    input  lsu_pkg::mem_op_e op_i,
    input  logic [1:0]       addr_lo_i,
    input  logic [31:0]      store_data_i,
    input  logic [31:0]      rdata_i,
    output logic             misaligned_o,
    output logic             is_load_o,
    output logic             is_store_o,
    output logic [3:0]       be_o,
    output logic [31:0]      wdata_o,
    output logic [31:0]      load_data_o
);
    import lsu_pkg::*;

    localparam logic [1:0] SZ_BYTE = 2'd0;
    localparam logic [1:0] SZ_HALF = 2'd1;
    localparam logic [1:0] SZ_WORD = 2'd2;

    logic [1:0]  size;
    logic        sext;                  // Sign extension for lb and lh.
    logic [4:0]  lane_shift;
    logic [31:0] rdata_shifted;

    assign lane_shift    = {addr_lo_i, 3'b000};
    assign rdata_shifted = rdata_i >> lane_shift;  // Addressed lane moves to bit 0.

    // Split the operation into direction, size and extension.
    always_comb begin
        is_load_o  = 1'b0;
        is_store_o = 1'b0;
        size       = SZ_BYTE;
        sext       = 1'b0;
        case (op_i)
            op_lb: begin
                is_load_o = 1'b1;
                sext      = 1'b1;
            end
            op_lh: begin
                is_load_o = 1'b1;
                size      = SZ_HALF;
                sext      = 1'b1;
            end
            op_lw: begin
                is_load_o = 1'b1;
                size      = SZ_WORD;
            end
            op_lbu: is_load_o = 1'b1;
            op_lhu: begin
                is_load_o = 1'b1;
                size      = SZ_HALF;
            end
            op_sb: is_store_o = 1'b1;
            op_sh: begin
                is_store_o = 1'b1;
                size       = SZ_HALF;
            end
            op_sw: begin
                is_store_o = 1'b1;
                size       = SZ_WORD;
            end
            default: ;                  // op_none decodes to nothing.
        endcase
    end

    assign misaligned_o = ((size == SZ_WORD) && (addr_lo_i != 2'b00)) ||
                          ((size == SZ_HALF) && addr_lo_i[0]);

    // Lane placement of store data and its byte enables.
    always_comb begin
        be_o    = 4'b0000;
        wdata_o = 32'h0;
        if (is_store_o) begin
            case (size)
                SZ_BYTE: begin
                    be_o    = 4'b0001 << addr_lo_i;
                    wdata_o = {24'h0, store_data_i[7:0]} << lane_shift;
                end
                SZ_HALF: begin
                    be_o    = 4'b0011 << addr_lo_i;
                    wdata_o = {16'h0, store_data_i[15:0]} << lane_shift;
                end
                default: begin
                    be_o    = 4'b1111;
                    wdata_o = store_data_i;
                end
            endcase
        end
    end

    // Extraction of the addressed bytes, then extension to 32 bits.
    always_comb begin
        case (size)
            SZ_BYTE: load_data_o = {{24{sext & rdata_shifted[7]}}, rdata_shifted[7:0]};
            SZ_HALF: load_data_o = {{16{sext & rdata_shifted[15]}}, rdata_shifted[15:0]};
            default: load_data_o = rdata_i;
        endcase
    end

endmodule

// File: rtl/lsu_ctrl.sv
//==============================
// Access FSM with one outstanding access.
// Requests with no load or store operation are ignored.
//==============================
module lsu_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic valid_i,
    input  logic misaligned_i,
    input  logic is_load_i,
    input  logic is_store_i,
    input  logic gnt_i,
    input  logic rvalid_i,
    output logic bus_req_o,
    output logic bus_we_o,
    output logic stall_o,
    output logic wb_we_o
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait_read,
        st_wait_write
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   access;

    assign access    = is_load_i | is_store_i;
    assign bus_req_o = valid_i & ~misaligned_i & access & (state_q == st_idle);
    assign bus_we_o  = is_store_i;

    always_comb begin
        state_d = state_q;
        stall_o = 1'b0;
        wb_we_o = 1'b0;
        case (state_q)
            st_idle: begin
                if (bus_req_o) begin
                    stall_o = 1'b1;     // Stall starts in the request cycle.
                    if (gnt_i) begin
                        state_d = is_load_i ? st_wait_read : st_wait_write;
                    end
                end
            end
            st_wait_read: begin
                if (rvalid_i) begin
                    wb_we_o = 1'b1;     // Load data is on the lanes now.
                    state_d = st_idle;
                end else begin
                    stall_o = 1'b1;
                end
            end
            st_wait_write: begin
                if (rvalid_i) begin
                    state_d = st_idle;
                end else begin
                    stall_o = 1'b1;
                end
            end
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// File: rtl/lsu_pkg.sv
//==============================
// Shared types for the load/store unit and its RAM.
// The RAM holds RAM_WORDS words and decodes only address bits 9 to 2.
//==============================
package lsu_pkg;

    localparam int RAM_WORDS = 256;     // Depth of the data RAM in words.
    localparam int RAM_AW    = 8;       // Word index width.

    // Memory operation carried with each core request.
    typedef enum logic [3:0] {
        op_none = 4'd0,
        op_lb   = 4'd1,
        op_lh   = 4'd2,
        op_lw   = 4'd3,
        op_lbu  = 4'd4,
        op_lhu  = 4'd5,
        op_sb   = 4'd6,
        op_sh   = 4'd7,
        op_sw   = 4'd8
    } mem_op_e;

    // Request from the core, held steady while the stall is high.
    typedef struct packed {
        logic        valid;
        mem_op_e     op;
        logic [31:0] addr;              // Byte address.
        logic [31:0] wdata;             // Store data in the low bits.
    } lsu_req_t;

    // Request toward the data RAM.
    typedef struct packed {
        logic        req;
        logic        we;                // High for stores.
        logic [3:0]  be;                // One enable per byte lane.
        logic [31:0] addr;              // Word aligned.
        logic [31:0] wdata;             // Already placed on its lanes.
    } bus_req_t;

    // Register write-back toward the core.
    typedef struct packed {
        logic        we;                // One-cycle pulse per load.
        logic [31:0] data;              // Extended load result.
    } lsu_wb_t;

endpackage

// File: rtl/lsu_top.sv
//==============================
// Load/store stage around the data RAM.
// misaligned_o is only reported; the request is dropped.
//==============================
module lsu_top (
    input  logic              clk,
    input  logic              rst_n,
    input  lsu_pkg::lsu_req_t req_i,
    input  logic              hold_i,
    output logic              stall_o,
    output logic              misaligned_o,
    output lsu_pkg::lsu_wb_t  wb_o
);
    import lsu_pkg::*;

    logic        misaligned;
    logic        is_load;
    logic        is_store;
    logic [3:0]  be;
    logic [31:0] wdata;
    logic [31:0] load_data;
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
    logic        bus_req;
    logic        bus_we;
    logic        wb_we;
    bus_req_t    bus;

    lsu_align align_i (
        .op_i         (req_i.op),
        .addr_lo_i    (req_i.addr[1:0]),
        .store_data_i (req_i.wdata),
        .rdata_i      (rdata),
        .misaligned_o (misaligned),
        .is_load_o    (is_load),
        .is_store_o   (is_store),
        .be_o         (be),
        .wdata_o      (wdata),
        .load_data_o  (load_data)
    );

    lsu_ctrl ctrl_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid_i      (req_i.valid),
        .misaligned_i (misaligned),
        .is_load_i    (is_load),
        .is_store_i   (is_store),
        .gnt_i        (gnt),
        .rvalid_i     (rvalid),
        .bus_req_o    (bus_req),
        .bus_we_o     (bus_we),
        .stall_o      (stall_o),
        .wb_we_o      (wb_we)
    );

    assign bus.req   = bus_req;
    assign bus.we    = bus_we;
    assign bus.be    = be;
    assign bus.addr  = {req_i.addr[31:2], 2'b00};  // RAM sees word addresses only.
    assign bus.wdata = wdata;

    data_ram ram_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .bus_i    (bus),
        .hold_i   (hold_i),
        .gnt_o    (gnt),
        .rvalid_o (rvalid),
        .rdata_o  (rdata)
    );

    assign misaligned_o = req_i.valid & misaligned;
    assign wb_o.we      = wb_we;
    assign wb_o.data    = load_data;

endmodule

// File: verif/lsu_chk.sv
//==============================
// Bound checker for lsu_top; the shadow memory is valid only after a full preload.
// Assumes the core holds its request while stall_o is high.
//==============================
module lsu_chk (
    input logic              clk,
    input logic              rst_n,
    input lsu_pkg::lsu_req_t req_i,
    input logic              hold_i,
    input logic              stall_i,
    input logic              misaligned_i,
    input lsu_pkg::lsu_wb_t  wb_i
);
    import lsu_pkg::*;

    logic [7:0]  shadow_q [4*RAM_WORDS];  // One entry per byte address.
    logic [2:0]  nbytes_c;
    logic        is_load_c;
    logic        is_store_c;
    logic        misaligned_c;
    logic        req_c;
    logic        grant_c;
    logic        resp_q;
    logic        resp_load_q;
    logic [31:0] exp_data_q;
    int          fail_count = 0;          // Read by the testbench at the end of the run.

    function automatic logic [2:0] access_bytes(input mem_op_e op);
        case (op)
            op_lb, op_lbu, op_sb: return 3'd1;
            op_lh, op_lhu, op_sh: return 3'd2;
            op_lw, op_sw:         return 3'd4;
            default:              return 3'd0;
        endcase
    endfunction

    // Little-endian bytes from the shadow, then extended by the load type.
    function automatic logic [31:0] load_value(input mem_op_e op, input logic [9:0] addr);
        logic [31:0] bytes_le;
        bytes_le = {shadow_q[addr + 10'd3], shadow_q[addr + 10'd2],
                    shadow_q[addr + 10'd1], shadow_q[addr]};
        case (op)
            op_lb:   return {{24{bytes_le[7]}}, bytes_le[7:0]};
            op_lbu:  return {24'h0, bytes_le[7:0]};
            op_lh:   return {{16{bytes_le[15]}}, bytes_le[15:0]};
            op_lhu:  return {16'h0, bytes_le[15:0]};
            default: return bytes_le;
        endcase
    endfunction

    assign nbytes_c     = access_bytes(req_i.op);
    assign is_load_c    = req_i.op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
    assign is_store_c   = req_i.op inside {op_sb, op_sh, op_sw};
    assign misaligned_c = (nbytes_c != 3'd0) &&
                          ((req_i.addr[1:0] & 2'(nbytes_c - 3'd1)) != 2'b00);
    assign req_c   = req_i.valid && (is_load_c || is_store_c) && !misaligned_c && !resp_q;
    assign grant_c = req_c && !hold_i;    // Grant happens on the edge that ends this cycle.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_q      <= 1'b0;
            resp_load_q <= 1'b0;
            exp_data_q  <= 32'h0;
        end else begin
            resp_q      <= grant_c;       // The response cycle follows the grant.
            resp_load_q <= grant_c && is_load_c;
            if (grant_c && is_load_c) begin
                exp_data_q <= load_value(req_i.op, req_i.addr[9:0]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant_c && is_store_c) begin
            for (int i = 0; i < 4; i++) begin
                if (3'(i) < nbytes_c) begin
                    shadow_q[req_i.addr[9:0] + 10'(i)] <= req_i.wdata[8*i +: 8];
                end
            end
        end
    end

    a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !req_c && !resp_q |-> !stall_i && !wb_i.we)
        else begin
            fail_count++;
            $error("FAILED quiet_cycle: expected stall 0 we 0, actual stall %b we %b",
                   stall_i, wb_i.we);
        end

    a_req_stall: assert property (@(posedge clk) disable iff (!rst_n)
        req_c |-> stall_i && !wb_i.we)
        else begin
            fail_count++;
            $error("FAILED request_stall: expected stall 1 we 0, actual stall %b we %b",
                   stall_i, wb_i.we);
        end

    a_resp: assert property (@(posedge clk) disable iff (!rst_n)
        resp_q |-> !stall_i && (wb_i.we == resp_load_q))
        else begin
            fail_count++;
            $error("FAILED response_cycle: expected stall 0 we %b, actual stall %b we %b",
                   resp_load_q, stall_i, wb_i.we);
        end

    a_load_data: assert property (@(posedge clk) disable iff (!rst_n)
        resp_q && resp_load_q |-> wb_i.data == exp_data_q)
        else begin
            fail_count++;
            $error("FAILED load_data: expected %h, actual %h", exp_data_q, wb_i.data);
        end

    a_misaligned: assert property (@(posedge clk) disable iff (!rst_n)
        misaligned_i == (req_i.valid && misaligned_c))
        else begin
            fail_count++;
            $error("FAILED misaligned: expected %b, actual %b",
                   req_i.valid && misaligned_c, misaligned_i);
        end

endmodule

bind lsu_top lsu_chk chk_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (req_i),
    .hold_i       (hold_i),
    .stall_i      (stall_o),
    .misaligned_i (misaligned_o),
    .wb_i         (wb_o)
);

// File: verif/lsu_tb.sv
//==============================
// Testbench for lsu_top; values are checked by the bound lsu_chk.
// Loads are meaningful only after the preload pass over every RAM word.
//==============================
module lsu_tb;
    import lsu_pkg::*;

    localparam int          STALL_LIMIT = 64;
    localparam int          RANDOM_OPS  = 400;
    localparam logic [31:0] WINDOW_MASK = 32'h0000_003f;  // Sixteen words near address 0.

    logic        clk;
    logic        rst_n;
    lsu_req_t    req;
    logic        hold;
    logic        stall;
    logic        misaligned;
    lsu_wb_t     wb;
    logic [31:0] rng_q;
    int          timeouts;
    int          assert_fails;

    lsu_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_i        (req),
        .hold_i       (hold),
        .stall_o      (stall),
        .misaligned_o (misaligned),
        .wb_o         (wb)
    );

    always #2 clk = ~clk;

    // Linear congruential generator, one step per call.
    function automatic logic [31:0] next_random();
        rng_q = rng_q * 32'd1664525 + 32'd1013904223;
        return rng_q;
    endfunction

    // The busy arbiter shows up in about a third of the cycles.
    function automatic logic random_hold();
        logic [31:0] r;
        r = next_random();
        return r[31:28] < 4'd5;
    endfunction

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            req.valid = 1'b0;
            req.op    = op_none;
            hold      = random_hold();
            @(negedge clk);
        end
    endtask

    // Called on a falling edge and returns on the falling edge after the stall ends.
    task automatic issue(input mem_op_e op, input logic [31:0] addr, input logic [31:0] data);
        int cycles;
        cycles    = 0;
        req.valid = 1'b1;
        req.op    = op;
        req.addr  = addr;
        req.wdata = data;
        hold      = random_hold();
        #1;                               // Stall settles well before the rising edge.
        while (stall && cycles < STALL_LIMIT) begin
            @(negedge clk);
            hold = random_hold();
            #1;
            cycles++;
        end
        if (stall) begin
            timeouts++;
            $display("Timeout: stall_o still high after %0d cycles for %s at address %h",
                     STALL_LIMIT, op.name(), addr);
        end
        @(negedge clk);
    endtask

    task automatic random_op();
        logic [31:0] r;
        logic [31:0] addr;
        mem_op_e     op;
        r = next_random();
        if (r[31:28] == 4'd0) begin
            idle_cycles(1);               // Occasional gap with valid low.
        end else begin
            op   = mem_op_e'(4'(r[27:16] % 12'd8) + 4'd1);
            addr = next_random() & WINDOW_MASK;  // Low bits stay random for misalignment.
            issue(op, addr, next_random());
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        req          = '0;
        hold         = 1'b0;
        rng_q        = 32'he1d4470e;
        timeouts     = 0;
        assert_fails = 0;

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        idle_cycles(4);                   // Nothing may stall before the first request.

        // Give every RAM word a known value.
        for (int w = 0; w < RAM_WORDS && timeouts == 0; w++) begin
            issue(op_sw, 32'(w) << 2, next_random());
        end

        for (int n = 0; n < RANDOM_OPS && timeouts == 0; n++) begin
            random_op();
        end
        idle_cycles(2);

        assert_fails = dut_i.chk_i.fail_count;
        $display("Checks done: %0d assertion failures, %0d timeouts", assert_fails, timeouts);
        if (assert_fails == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
rtl/lsu_pkg.sv
rtl/lsu_align.sv
rtl/lsu_ctrl.sv
rtl/data_ram.sv
rtl/lsu_top.sv
verif/lsu_chk.sv
verif/lsu_tb.sv
